/* Makefile */
# Verilator build and run for the memory command unit
# all variables can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mem_cmd_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_STR  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# build, run, then look for the pass line in the output
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
src/mem_cmd_pkg.sv
src/payload_fifo.sv
src/oh_ram.sv
src/cmd_decode.sv
src/mem_execute.sv
src/resp_result.sv
src/mem_cmd_top.sv
test/tb_mem_cmd_top.sv

/* src/cmd_decode.sv */
// command front end
// queues commands in a small fifo, then decodes the head into one-hot
// operation flags and a bit write mask held in an output register
// reserved opcodes are popped and never reach execute

`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
   input  logic                            rd_clk,
   input  logic                            rst_n,
   // command port
   input  logic                            cmd_valid,
   output logic                            cmd_ready,
   input  logic [mem_cmd_pkg::OP_W-1:0]    cmd_op,
   input  logic [mem_cmd_pkg::TAG_W-1:0]   cmd_tag,
   input  logic [mem_cmd_pkg::ADDR_W-1:0]  cmd_addr,
   input  logic [mem_cmd_pkg::DATA_W-1:0]  cmd_data,
   input  logic [mem_cmd_pkg::MASK_W-1:0]  cmd_mask,
   // to execute
   output logic                            dec_valid,
   output logic                            dec_read,
   output logic                            dec_write,
   output logic                            dec_toggle,
   output logic [mem_cmd_pkg::TAG_W-1:0]   dec_tag,
   output logic [mem_cmd_pkg::ADDR_W-1:0]  dec_addr,
   output logic [mem_cmd_pkg::DATA_W-1:0]  dec_data,
   output logic [mem_cmd_pkg::DATA_W-1:0]  dec_wem,
   input  logic                            exe_ready
);

   mem_cmd_pkg::cmd_word_t cmd_in;
   mem_cmd_pkg::cmd_word_t head;
   logic                   head_valid;
   logic                   head_pop;
   logic                   head_rsvd;   // opcode 3
   logic                   reg_free;
   logic                   load;
   logic [mem_cmd_pkg::DATA_W-1:0] head_wem;

   // pack the loose fields
   assign cmd_in = '{op: cmd_op, tag: cmd_tag, addr: cmd_addr,
                     data: cmd_data, mask: cmd_mask};

   payload_fifo #(
      .payload_t (mem_cmd_pkg::cmd_word_t),
      .DEPTH     (mem_cmd_pkg::CMD_FIFO_DEPTH)
   ) cmd_fifo_inst (
      .rd_clk    (rd_clk),
      .rst_n     (rst_n),
      .in_valid  (cmd_valid),
      .in_ready  (cmd_ready),
      .in_data   (cmd_in),
      .out_valid (head_valid),
      .out_ready (head_pop),
      .out_data  (head),
      .count     ()
   );

   // ####################
   // head decode
   assign head_rsvd = !(head.op == mem_cmd_pkg::OP_READ ||
                        head.op == mem_cmd_pkg::OP_WRITE ||
                        head.op == mem_cmd_pkg::OP_TOGGLE);
   assign reg_free  = !dec_valid || exe_ready;   // empty or leaving now
   assign head_pop  = head_rsvd || reg_free;     // reserved just drained
   assign load      = head_valid && reg_free && !head_rsvd;

   // byte mask to bit mask
   always_comb begin
      for (int i = 0; i < mem_cmd_pkg::MASK_W; i++) begin
         head_wem[8*i +: 8] = {8{head.mask[i]}};
      end
   end

   // output register, flags are control and get reset
   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         dec_valid  <= 1'b0;
         dec_read   <= 1'b0;
         dec_write  <= 1'b0;
         dec_toggle <= 1'b0;
      end else if (reg_free) begin
         dec_valid  <= load;
         dec_read   <= load && (head.op == mem_cmd_pkg::OP_READ);
         dec_write  <= load && (head.op == mem_cmd_pkg::OP_WRITE);
         dec_toggle <= load && (head.op == mem_cmd_pkg::OP_TOGGLE);
      end
   end

   always_ff @(posedge rd_clk) begin
      if (load) begin
         dec_tag  <= head.tag;
         dec_addr <= head.addr;
         dec_data <= head.data;
         dec_wem  <= head_wem;
      end
   end

endmodule

`default_nettype wire

/* src/mem_cmd_pkg.sv */
// shared widths, opcodes and payload layouts for the memory command unit
// every module refers to these by scoped name

`default_nettype none

package mem_cmd_pkg;

   // ####################
   // widths
   localparam int DATA_W    = 32;                  // data word
   localparam int MASK_W    = DATA_W / 8;          // one bit per byte
   localparam int MEM_DEPTH = 32;                  // words in the ram
   localparam int ADDR_W    = $clog2(MEM_DEPTH);   // 5 bits
   localparam int TAG_W     = 4;                   // response tag
   localparam int OP_W      = 2;

   // ####################
   // opcodes, 3 is reserved and dropped
   localparam logic [OP_W-1:0] OP_READ   = 2'd0;
   localparam logic [OP_W-1:0] OP_WRITE  = 2'd1;
   localparam logic [OP_W-1:0] OP_TOGGLE = 2'd2;

   // ####################
   // buffer sizes
   localparam int CMD_FIFO_DEPTH  = 2;
   localparam int RESP_FIFO_DEPTH = 4;   // room check assumes >= 2

   // command as stored in the input fifo, 47 bits
   typedef struct packed {
      logic [OP_W-1:0]   op;
      logic [TAG_W-1:0]  tag;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [MASK_W-1:0] mask;
   } cmd_word_t;

   // response as stored in the output fifo, 36 bits
   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [DATA_W-1:0] data;
   } resp_word_t;

endpackage

`default_nettype wire

/* src/mem_cmd_top.sv */
// top of the command driven memory access unit
// decode -> execute -> result, all on rd_clk
// commands in on cmd_*, read and toggle responses out on resp_* in order

`timescale 1ns/1ps
`default_nettype none

module mem_cmd_top (
   input  logic                            rd_clk,
   input  logic                            rst_n,
   // command port
   input  logic                            cmd_valid,
   output logic                            cmd_ready,
   input  logic [mem_cmd_pkg::OP_W-1:0]    cmd_op,
   input  logic [mem_cmd_pkg::TAG_W-1:0]   cmd_tag,
   input  logic [mem_cmd_pkg::ADDR_W-1:0]  cmd_addr,
   input  logic [mem_cmd_pkg::DATA_W-1:0]  cmd_data,
   input  logic [mem_cmd_pkg::MASK_W-1:0]  cmd_mask,
   // response port
   output logic                            resp_valid,
   input  logic                            resp_ready,
   output logic [mem_cmd_pkg::TAG_W-1:0]   resp_tag,
   output logic [mem_cmd_pkg::DATA_W-1:0]  resp_data
);

   // ####################
   // decode to execute
   logic                           dec_valid;
   logic                           dec_read;
   logic                           dec_write;
   logic                           dec_toggle;
   logic [mem_cmd_pkg::TAG_W-1:0]  dec_tag;
   logic [mem_cmd_pkg::ADDR_W-1:0] dec_addr;
   logic [mem_cmd_pkg::DATA_W-1:0] dec_data;
   logic [mem_cmd_pkg::DATA_W-1:0] dec_wem;
   logic                           exe_ready;

   // execute to result
   logic                           rd_ret_valid;
   logic [mem_cmd_pkg::TAG_W-1:0]  rd_ret_tag;
   logic [mem_cmd_pkg::DATA_W-1:0] rd_ret_data;
   logic                           resp_room;

   cmd_decode cmd_decode_inst (
      .rd_clk     (rd_clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_op     (cmd_op),
      .cmd_tag    (cmd_tag),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .cmd_mask   (cmd_mask),
      .dec_valid  (dec_valid),
      .dec_read   (dec_read),
      .dec_write  (dec_write),
      .dec_toggle (dec_toggle),
      .dec_tag    (dec_tag),
      .dec_addr   (dec_addr),
      .dec_data   (dec_data),
      .dec_wem    (dec_wem),
      .exe_ready  (exe_ready)
   );

   mem_execute mem_execute_inst (
      .rd_clk       (rd_clk),
      .rst_n        (rst_n),
      .dec_valid    (dec_valid),
      .dec_read     (dec_read),
      .dec_write    (dec_write),
      .dec_toggle   (dec_toggle),
      .dec_tag      (dec_tag),
      .dec_addr     (dec_addr),
      .dec_data     (dec_data),
      .dec_wem      (dec_wem),
      .exe_ready    (exe_ready),
      .resp_room    (resp_room),
      .rd_ret_valid (rd_ret_valid),
      .rd_ret_tag   (rd_ret_tag),
      .rd_ret_data  (rd_ret_data)
   );

   resp_result resp_result_inst (
      .rd_clk       (rd_clk),
      .rst_n        (rst_n),
      .rd_ret_valid (rd_ret_valid),
      .rd_ret_tag   (rd_ret_tag),
      .rd_ret_data  (rd_ret_data),
      .resp_room    (resp_room),
      .resp_valid   (resp_valid),
      .resp_ready   (resp_ready),
      .resp_tag     (resp_tag),
      .resp_data    (resp_data)
   );

endmodule

`default_nettype wire

/* src/mem_execute.sv */
// memory access stage
// writes go straight to the ram, reads and toggles fire rd_en and
// return one cycle later through a one deep pipeline register
// a toggle writes old ^ data back in the next cycle and stalls intake

`timescale 1ns/1ps
`default_nettype none

module mem_execute (
   input  logic                            rd_clk,
   input  logic                            rst_n,
   // from decode
   input  logic                            dec_valid,
   input  logic                            dec_read,
   input  logic                            dec_write,
   input  logic                            dec_toggle,
   input  logic [mem_cmd_pkg::TAG_W-1:0]   dec_tag,
   input  logic [mem_cmd_pkg::ADDR_W-1:0]  dec_addr,
   input  logic [mem_cmd_pkg::DATA_W-1:0]  dec_data,
   input  logic [mem_cmd_pkg::DATA_W-1:0]  dec_wem,
   output logic                            exe_ready,
   // from result
   input  logic                            resp_room,
   // read return
   output logic                            rd_ret_valid,
   output logic [mem_cmd_pkg::TAG_W-1:0]   rd_ret_tag,
   output logic [mem_cmd_pkg::DATA_W-1:0]  rd_ret_data
);

   logic accept;
   logic rd_en;
   logic wb_pending;   // toggle write back this cycle

   // pipeline stage for the returning read
   logic                           p_valid;
   logic                           p_toggle;
   logic [mem_cmd_pkg::TAG_W-1:0]  p_tag;
   logic [mem_cmd_pkg::ADDR_W-1:0] p_addr;
   logic [mem_cmd_pkg::DATA_W-1:0] p_data;
   logic [mem_cmd_pkg::DATA_W-1:0] p_wem;

   logic                           wr_en;
   logic [mem_cmd_pkg::ADDR_W-1:0] wr_addr;
   logic [mem_cmd_pkg::DATA_W-1:0] wr_wem;
   logic [mem_cmd_pkg::DATA_W-1:0] wr_din;
   logic [mem_cmd_pkg::DATA_W-1:0] rd_dout;
   mem_cmd_pkg::resp_word_t        ret_word;

   // ####################
   // intake
   assign wb_pending = p_valid && p_toggle;
   assign exe_ready  = !wb_pending && (dec_write || resp_room);   // writes skip room
   assign accept     = dec_valid && exe_ready;
   assign rd_en      = accept && (dec_read || dec_toggle);

   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         p_valid  <= 1'b0;
         p_toggle <= 1'b0;
      end else begin
         p_valid  <= rd_en;
         p_toggle <= rd_en && dec_toggle;
      end
   end

   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         p_tag  <= dec_tag;
         p_addr <= dec_addr;
         p_data <= dec_data;
         p_wem  <= dec_wem;
      end
   end

   // ####################
   // write mux, intake is blocked during write back
   assign wr_en   = wb_pending || (accept && dec_write);
   assign wr_addr = wb_pending ? p_addr : dec_addr;
   assign wr_wem  = wb_pending ? p_wem : dec_wem;
   assign wr_din  = wb_pending ? (rd_dout ^ p_data) : dec_data;   // ram masks

   oh_ram #(
      .DW       (mem_cmd_pkg::DATA_W),
      .DEPTH    (mem_cmd_pkg::MEM_DEPTH),
      .REG      (1),
      .DUALPORT (1),
      .AW       (mem_cmd_pkg::ADDR_W)
   ) ram_inst (
      .rd_clk  (rd_clk),
      .rd_en   (rd_en),
      .rd_addr (dec_addr),
      .rd_dout (rd_dout),
      .wr_clk  (rd_clk),   // single clock domain
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_wem  (wr_wem),
      .wr_din  (wr_din)
   );

   // return old word with its tag
   assign ret_word     = '{tag: p_tag, data: rd_dout};
   assign rd_ret_valid = p_valid;
   assign rd_ret_tag   = ret_word.tag;
   assign rd_ret_data  = ret_word.data;

endmodule

`default_nettype wire

/* src/oh_ram.sv */
// generic word memory with a per-bit write enable vector
// REG = 1 registers the read word while rd_en is high
// DUALPORT = 0 reads from the write address instead of rd_addr

`timescale 1ns/1ps
`default_nettype none

module oh_ram #(
   parameter int DW       = 32,              // word width
   parameter int DEPTH    = 32,              // number of words
   parameter int REG      = 1,               // registered read data
   parameter int DUALPORT = 1,               // separate read address
   parameter int AW       = $clog2(DEPTH)    // address width
) (
   // read side
   input  logic          rd_clk,
   input  logic          rd_en,
   input  logic [AW-1:0] rd_addr,
   output logic [DW-1:0] rd_dout,
   // write side
   input  logic          wr_clk,
   input  logic          wr_en,
   input  logic [AW-1:0] wr_addr,
   input  logic [DW-1:0] wr_wem,   // bit enables
   input  logic [DW-1:0] wr_din
);

   logic [DW-1:0] ram [DEPTH];   // contents undefined until written
   logic [AW-1:0] dp_addr;
   logic [DW-1:0] rdata;
   logic [DW-1:0] rd_q;

   // single port mode shares the write address
   assign dp_addr = (DUALPORT == 1) ? rd_addr : wr_addr;

   // ####################
   // write port
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         // keep bits outside the enable vector
         ram[wr_addr] <= (ram[wr_addr] & ~wr_wem) | (wr_din & wr_wem);
      end
   end

   // ####################
   // read port
   assign rdata = ram[dp_addr];

   always_ff @(posedge rd_clk) begin
      if (rd_en) rd_q <= rdata;   // hold last word otherwise
   end

   assign rd_dout = (REG == 1) ? rd_q : rdata;

endmodule

`default_nettype wire

/* src/payload_fifo.sv */
// small synchronous fifo, payload type and depth set by parameters
// in_ready comes from a register so it stays low while in reset
// out_valid follows occupancy, push and pop allowed in one cycle

`timescale 1ns/1ps
`default_nettype none

module payload_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 2
) (
   input  logic                       rd_clk,
   input  logic                       rst_n,
   input  logic                       in_valid,
   output logic                       in_ready,
   input  payload_t                   in_data,
   output logic                       out_valid,
   input  logic                       out_ready,
   output payload_t                   out_data,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];   // storage, no reset
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] count_nxt;
   logic             ready_q;
   logic             push;
   logic             pop;

   assign push      = in_valid & ready_q;
   assign pop       = out_valid & out_ready;
   assign count_nxt = count_q + CNT_W'(push) - CNT_W'(pop);

   assign in_ready  = ready_q;
   assign out_valid = (count_q != '0);   // not empty
   assign out_data  = mem[rd_ptr];
   assign count     = count_q;

   // ####################
   // pointers and occupancy
   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
         ready_q <= 1'b0;   // held off until out of reset
      end else begin
         count_q <= count_nxt;
         ready_q <= (count_nxt != CNT_W'(DEPTH));
         if (push) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) wr_ptr <= '0;   // wrap
            else wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) rd_ptr <= '0;
            else rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // data store
   always_ff @(posedge rd_clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

endmodule

`default_nettype wire

/* src/resp_result.sv */
// response stage
// every read return is pushed into the response fifo, the head goes
// out on the resp port under valid/ready
// resp_room keeps two slots free for reads already committed

`timescale 1ns/1ps
`default_nettype none

module resp_result (
   input  logic                            rd_clk,
   input  logic                            rst_n,
   // read return
   input  logic                            rd_ret_valid,
   input  logic [mem_cmd_pkg::TAG_W-1:0]   rd_ret_tag,
   input  logic [mem_cmd_pkg::DATA_W-1:0]  rd_ret_data,
   output logic                            resp_room,
   // response port
   output logic                            resp_valid,
   input  logic                            resp_ready,
   output logic [mem_cmd_pkg::TAG_W-1:0]   resp_tag,
   output logic [mem_cmd_pkg::DATA_W-1:0]  resp_data
);

   localparam int CNT_W = $clog2(mem_cmd_pkg::RESP_FIFO_DEPTH + 1);

   mem_cmd_pkg::resp_word_t ret_word;
   mem_cmd_pkg::resp_word_t head;
   logic [CNT_W-1:0]        fill;

   assign ret_word = '{tag: rd_ret_tag, data: rd_ret_data};

   // ####################
   // response buffer
   // never full on push, room check upstream guarantees a slot
   payload_fifo #(
      .payload_t (mem_cmd_pkg::resp_word_t),
      .DEPTH     (mem_cmd_pkg::RESP_FIFO_DEPTH)
   ) resp_fifo_inst (
      .rd_clk    (rd_clk),
      .rst_n     (rst_n),
      .in_valid  (rd_ret_valid),
      .in_ready  (),
      .in_data   (ret_word),
      .out_valid (resp_valid),
      .out_ready (resp_ready),
      .out_data  (head),
      .count     (fill)
   );

   // one return in flight plus one being issued
   assign resp_room = (fill <= CNT_W'(mem_cmd_pkg::RESP_FIFO_DEPTH - 2));

   // unpack head
   assign resp_tag  = head.tag;
   assign resp_data = head.data;

endmodule

`default_nettype wire

/* test/tb_mem_cmd_top.sv */
// testbench for the memory command unit
// drives random commands from a fixed seed on the falling edge and keeps
// a memory model plus a queue of expected responses
// responses are checked in order as they leave the DUT

`timescale 1ns/1ps
`default_nettype none

module tb_mem_cmd_top;

   localparam int WAIT_LIMIT = 400;   // cycles for any single wait
   localparam int RDY_ALWAYS = 0;
   localparam int RDY_RANDOM = 1;
   localparam int RDY_HOLD   = 2;

   logic                           rd_clk = 1'b0;
   logic                           rst_n;
   logic                           cmd_valid;
   logic                           cmd_ready;
   logic [mem_cmd_pkg::OP_W-1:0]   cmd_op;
   logic [mem_cmd_pkg::TAG_W-1:0]  cmd_tag;
   logic [mem_cmd_pkg::ADDR_W-1:0] cmd_addr;
   logic [mem_cmd_pkg::DATA_W-1:0] cmd_data;
   logic [mem_cmd_pkg::MASK_W-1:0] cmd_mask;
   logic                           resp_valid;
   logic                           resp_ready;
   logic [mem_cmd_pkg::TAG_W-1:0]  resp_tag;
   logic [mem_cmd_pkg::DATA_W-1:0] resp_data;

   // ####################
   // model state
   logic [mem_cmd_pkg::DATA_W-1:0] model_mem [mem_cmd_pkg::MEM_DEPTH];
   logic [35:0]                    exp_q [$];      // {tag, data}
   logic [31:0]                    rng_state = 32'h7481_9340;
   logic [mem_cmd_pkg::TAG_W-1:0]  next_tag = '0;
   int                             resp_mode = RDY_ALWAYS;
   int                             hold_left = 0;  // cycles of resp_ready low
   logic                           saw_stall = 1'b0;

   always #50 rd_clk = ~rd_clk;   // 100 ns period

   mem_cmd_top mem_cmd_top_inst (
      .rd_clk     (rd_clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_op     (cmd_op),
      .cmd_tag    (cmd_tag),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .cmd_mask   (cmd_mask),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_tag   (resp_tag),
      .resp_data  (resp_data)
   );

   // ####################
   // helpers
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);   // advances global state
      return rng_state;
   endfunction

   // byte mask to bit lanes
   function automatic logic [31:0] byte_lanes(input logic [3:0] mask);
      logic [31:0] bits;
      for (int i = 0; i < 4; i++) bits[8*i +: 8] = {8{mask[i]}};
      return bits;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_equal(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      if (got !== want)
         abort_run($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, want));
   endtask

   // one falling edge, sets resp_ready and checks a response leaving now
   task automatic tick();
      logic [35:0] exp_word;
      @(negedge rd_clk);
      if (resp_mode == RDY_ALWAYS) resp_ready = 1'b1;
      else if (resp_mode == RDY_RANDOM) resp_ready = ((next_rand() & 32'h3) != 0);
      else begin
         resp_ready = 1'b0;
         hold_left--;
         if (hold_left <= 0) resp_mode = RDY_RANDOM;   // release
      end
      if (resp_valid && resp_ready) begin
         if (exp_q.size() == 0) abort_run("response arrived with nothing outstanding");
         exp_word = exp_q.pop_front();
         check_equal("resp_tag", resp_tag, exp_word[35:32]);
         check_equal("resp_data", resp_data, exp_word[31:0]);
      end
   endtask

   // model update at acceptance
   task automatic apply_model(input logic [1:0] op, input logic [3:0] tag,
                              input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
      logic [31:0] old;
      logic [31:0] bits;
      old  = model_mem[addr];
      bits = byte_lanes(mask);
      case (op)
         mem_cmd_pkg::OP_READ:  exp_q.push_back({tag, old});
         mem_cmd_pkg::OP_WRITE: model_mem[addr] = (old & ~bits) | (data & bits);
         mem_cmd_pkg::OP_TOGGLE: begin
            exp_q.push_back({tag, old});   // old word comes back
            model_mem[addr] = old ^ (data & bits);
         end
         default: ;   // reserved, dropped
      endcase
   endtask

   task automatic send_cmd(input logic [1:0] op, input logic [4:0] addr,
                           input logic [31:0] data, input logic [3:0] mask);
      int waited;
      waited = 0;
      tick();
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_tag   = next_tag;
      cmd_addr  = addr;
      cmd_data  = data;
      cmd_mask  = mask;
      while (!cmd_ready) begin   // fields held
         saw_stall = 1'b1;
         waited++;
         if (waited > WAIT_LIMIT) abort_run("timeout, command was never accepted");
         tick();
      end
      apply_model(op, next_tag, addr, data, mask);   // taken at next rising edge
      next_tag = next_tag + 1'b1;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         tick();
         cmd_valid = 1'b0;
      end
   endtask

   // wait for every expected response, then a quiet stretch
   task automatic drain_responses();
      int waited;
      waited = 0;
      tick();
      cmd_valid = 1'b0;
      while (exp_q.size() != 0) begin
         waited++;
         if (waited > WAIT_LIMIT) abort_run("timeout, expected responses did not arrive");
         tick();
      end
      for (int i = 0; i < 6; i++) begin
         tick();
         check_equal("resp_valid", resp_valid, 0);
      end
   endtask

   // ####################
   // main sequence
   initial begin
      logic [31:0] r;
      rst_n      = 1'b0;
      cmd_valid  = 1'b0;
      cmd_op     = '0;
      cmd_tag    = '0;
      cmd_addr   = '0;
      cmd_data   = '0;
      cmd_mask   = '0;
      resp_ready = 1'b0;

      for (int i = 0; i < 5; i++) begin   // reset, 5 rising edges
         @(negedge rd_clk);
         check_equal("cmd_ready", cmd_ready, 0);
         check_equal("resp_valid", resp_valid, 0);
      end
      rst_n = 1'b1;
      for (int i = 0; i < 4; i++) begin   // nothing sent yet
         tick();
         check_equal("resp_valid", resp_valid, 0);
      end

      // fill every word so reads are defined
      for (int a = 0; a < mem_cmd_pkg::MEM_DEPTH; a++)
         send_cmd(mem_cmd_pkg::OP_WRITE, 5'(a), next_rand(), 4'hf);
      drain_responses();

      // masked write then read back
      send_cmd(mem_cmd_pkg::OP_WRITE, 5'd5, next_rand(), 4'b0101);
      send_cmd(mem_cmd_pkg::OP_READ, 5'd5, 32'h0, 4'h0);
      drain_responses();

      // toggle with a read right behind it
      send_cmd(mem_cmd_pkg::OP_TOGGLE, 5'd7, next_rand(), 4'b1010);
      send_cmd(mem_cmd_pkg::OP_READ, 5'd7, 32'h0, 4'h0);
      drain_responses();

      // reserved opcodes mixed in
      send_cmd(mem_cmd_pkg::OP_READ, 5'd1, 32'h0, 4'h0);
      send_cmd(2'd3, 5'd1, next_rand(), 4'hf);
      send_cmd(mem_cmd_pkg::OP_READ, 5'd2, 32'h0, 4'h0);
      send_cmd(2'd3, 5'd3, next_rand(), 4'hf);
      send_cmd(mem_cmd_pkg::OP_TOGGLE, 5'd3, next_rand(), 4'b0110);
      send_cmd(mem_cmd_pkg::OP_READ, 5'd3, 32'h0, 4'h0);
      drain_responses();

      // long back-pressure, intake must stall
      saw_stall = 1'b0;
      hold_left = 60;
      resp_mode = RDY_HOLD;
      for (int i = 0; i < 16; i++)
         send_cmd(mem_cmd_pkg::OP_READ, 5'(next_rand()), 32'h0, 4'h0);
      if (!saw_stall) abort_run("cmd_ready never fell while responses were held back");
      drain_responses();

      // random traffic
      resp_mode = RDY_RANDOM;
      for (int n = 0; n < 2000; n++) begin
         r = next_rand();
         send_cmd(r[1:0], r[6:2], next_rand(), r[10:7]);
         if (r[13:12] == 2'd0) idle_cycles(int'(r[15:14]));
         if (r[23:16] == 8'd0) begin   // now and then a hold period
            hold_left = 20;
            resp_mode = RDY_HOLD;
         end
      end
      drain_responses();

      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire
